// ==== run_sim.sh ====
#!/bin/sh
# build and run the spu_core testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert --timescale 1ns/1ps \
    -f spu_core.f --top-module tb_spu_core -o sim_tb_spu_core

./obj_dir/sim_tb_spu_core 2>&1 | tee sim.log

if grep -q "^=== PASS ===$" sim.log; then
    echo "simulation passed"
else
    echo "simulation failed, see sim.log"
    exit 1
fi

// ==== spu_cfg.svh ====
`ifndef SPU_CFG_SVH
`define SPU_CFG_SVH

// ------------------------------------------------------------
// operand and result widths
// ------------------------------------------------------------
`define SPU_DATA_BITS       16          // width of each operand
`define SPU_RESULT_BITS     16          // width of each result

// ------------------------------------------------------------
// pipeline timing
// ------------------------------------------------------------
`define SPU_LATENCY         3           // cke-enabled edges, input to m_out

// ------------------------------------------------------------
// operator constants
// ------------------------------------------------------------
// the multiplier drops 8 fraction bits, so two 8.8 operands
// give an 8.8 product
`define SPU_MUL_SHIFT       8           // right shift before truncation
`define SPU_CLEAR_DATA      16'h0000    // value loaded by clear

`endif

// ==== spu_core.f ====
+incdir+.
spu_pkg.sv
spu_delay.sv
spu_op_mulu.sv
spu_op_addu.sv
spu_core.sv
tb_spu_core.sv

// ==== spu_core.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "spu_cfg.svh"

module spu_core (
    input  logic              clk,
    input  logic              reset,
    input  logic              cke,
    input  spu_pkg::spu_in_t  s_in,
    output spu_pkg::spu_out_t m_out
);

    import spu_pkg::*;

    spu_result_t mul_data;      // registered product
    spu_result_t sum_data;      // registered sum

    // ------------------------------------------------------------
    // both operators see the same operands and flags
    // ------------------------------------------------------------
    spu_op_mulu #(
        .LATENCY    (`SPU_LATENCY),
        .DATA_SHIFT (`SPU_MUL_SHIFT)
    ) u_mulu (
        .clk     (clk),
        .reset   (reset),
        .cke     (cke),
        .s_data0 (s_in.data0),
        .s_data1 (s_in.data1),
        .s_clear (s_in.clear),
        .s_valid (s_in.valid),
        .m_data  (mul_data)
    );

    spu_op_addu #(
        .LATENCY (`SPU_LATENCY)
    ) u_addu (
        .clk     (clk),
        .reset   (reset),
        .cke     (cke),
        .s_data0 (s_in.data0),
        .s_data1 (s_in.data1),
        .s_clear (s_in.clear),
        .s_valid (s_in.valid),
        .m_data  (sum_data)
    );

    assign m_out = spu_out_t'{mul: mul_data, sum: sum_data};   // same latency, same cycle

endmodule

`default_nettype wire

// ==== spu_delay.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "spu_cfg.svh"

module spu_delay #(
    parameter int                   LATENCY    = `SPU_LATENCY,
    parameter type                  payload_t  = spu_pkg::spu_result_t,
    parameter spu_pkg::spu_result_t CLEAR_DATA = '0
) (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 cke,
    input  payload_t             s_payload,
    input  logic                 s_valid,
    input  logic                 s_clear,
    output spu_pkg::spu_result_t m_data
);

    import spu_pkg::*;

    payload_t last_payload;     // payload in front of the output register
    logic     last_valid;
    logic     last_clear;

    // ------------------------------------------------------------
    // LATENCY-1 pipeline stages
    // ------------------------------------------------------------
    generate
        if (LATENCY > 1) begin : g_stages
            payload_t           stg_payload [LATENCY-1];
            logic [LATENCY-2:0] stg_valid;
            logic [LATENCY-2:0] stg_clear;

            always_ff @(posedge clk) begin
                if (cke) begin
                    stg_payload[0] <= s_payload;
                    for (int i = 1; i < LATENCY-1; i++) begin
                        stg_payload[i] <= stg_payload[i-1];
                    end
                end
            end

            always_ff @(posedge clk) begin
                if (reset) begin
                    stg_valid <= '0;
                    stg_clear <= '0;
                end else if (cke) begin
                    stg_valid[0] <= s_valid;
                    stg_clear[0] <= s_clear;
                    for (int i = 1; i < LATENCY-1; i++) begin
                        stg_valid[i] <= stg_valid[i-1];
                        stg_clear[i] <= stg_clear[i-1];
                    end
                end
            end

            assign last_payload = stg_payload[LATENCY-2];
            assign last_valid   = stg_valid[LATENCY-2];
            assign last_clear   = stg_clear[LATENCY-2];
        end else begin : g_direct
            assign last_payload = s_payload;    // output register is the only stage
            assign last_valid   = s_valid;
            assign last_clear   = s_clear;
        end
    endgenerate

    // ------------------------------------------------------------
    // output register: clear, then load, else hold
    // ------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (reset) begin
            m_data <= CLEAR_DATA;
        end else if (cke) begin
            if (last_clear) begin
                m_data <= CLEAR_DATA;
            end else if (last_valid) begin
                m_data <= spu_result_t'(last_payload);  // drops any extra payload bits
            end
        end
    end

    a_hold_on_stall: assert property (@(posedge clk)
        !reset && !cke |=> $stable(m_data));

    a_clear_reaches_out: assert property (@(posedge clk)
        !reset && cke && last_clear |=> m_data == CLEAR_DATA);

endmodule

`default_nettype wire

// ==== spu_op_addu.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "spu_cfg.svh"

module spu_op_addu #(
    parameter int LATENCY = `SPU_LATENCY
) (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  cke,
    input  spu_pkg::spu_operand_t s_data0,
    input  spu_pkg::spu_operand_t s_data1,
    input  logic                  s_clear,
    input  logic                  s_valid,
    output spu_pkg::spu_result_t  m_data
);

    import spu_pkg::*;

    // sum with the carry kept as its top bit
    typedef logic [$bits(spu_operand_t):0] sum_t;

    sum_t sum;

    // ------------------------------------------------------------
    // add with carry
    // ------------------------------------------------------------
    assign sum = sum_t'(s_data0) + sum_t'(s_data1);   // carry lands in msb

    // carry travels with the sum and is cut at the output register,
    // which makes the result wrap modulo 2^16
    spu_delay #(
        .LATENCY    (LATENCY),
        .payload_t  (sum_t),
        .CLEAR_DATA (spu_result_t'(`SPU_CLEAR_DATA))
    ) u_delay (
        .clk       (clk),
        .reset     (reset),
        .cke       (cke),
        .s_payload (sum),
        .s_valid   (s_valid),
        .s_clear   (s_clear),
        .m_data    (m_data)
    );

endmodule

`default_nettype wire

// ==== spu_op_mulu.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "spu_cfg.svh"

module spu_op_mulu #(
    parameter int LATENCY    = `SPU_LATENCY,
    parameter int DATA_SHIFT = `SPU_MUL_SHIFT
) (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  cke,
    input  spu_pkg::spu_operand_t s_data0,
    input  spu_pkg::spu_operand_t s_data1,
    input  logic                  s_clear,
    input  logic                  s_valid,
    output spu_pkg::spu_result_t  m_data
);

    import spu_pkg::*;

    localparam int PRODUCT_BITS = 2 * $bits(spu_operand_t);
    localparam int RESULT_BITS  = $bits(spu_result_t);

    logic [PRODUCT_BITS-1:0] product;           // full unsigned product
    logic [PRODUCT_BITS-1:0] product_shifted;
    spu_result_t             result;

    // ------------------------------------------------------------
    // multiply, shift, truncate
    // ------------------------------------------------------------
    // operands widened first so no product bits are lost
    assign product         = PRODUCT_BITS'(s_data0) * PRODUCT_BITS'(s_data1);
    assign product_shifted = product >> DATA_SHIFT;         // drop fraction bits
    assign result          = spu_result_t'(product_shifted); // keep low result bits

    // ------------------------------------------------------------
    // fixed latency with clear and hold
    // ------------------------------------------------------------
    spu_delay #(
        .LATENCY    (LATENCY),
        .payload_t  (spu_result_t),
        .CLEAR_DATA (spu_result_t'(`SPU_CLEAR_DATA))
    ) u_delay (
        .clk       (clk),
        .reset     (reset),
        .cke       (cke),
        .s_payload (result),
        .s_valid   (s_valid),
        .s_clear   (s_clear),
        .m_data    (m_data)
    );

    // a shift past the top would leave result bits with no source
    a_shift_range: assert property (@(posedge clk) disable iff (reset)
        (DATA_SHIFT + RESULT_BITS) <= PRODUCT_BITS);

endmodule

`default_nettype wire

// ==== spu_pkg.sv ====
`default_nettype none

`include "spu_cfg.svh"

package spu_pkg;

    // ------------------------------------------------------------
    // scalar types
    // ------------------------------------------------------------
    typedef logic [`SPU_DATA_BITS-1:0]   spu_operand_t;   // one unsigned operand
    typedef logic [`SPU_RESULT_BITS-1:0] spu_result_t;    // one operator result

    // ------------------------------------------------------------
    // core-level bundles
    // ------------------------------------------------------------
    // one operand pair plus its per-cycle flags
    typedef struct packed {
        spu_operand_t data0;    // first operand
        spu_operand_t data1;    // second operand
        logic         clear;    // load clear value, wins over valid
        logic         valid;    // produce a result
    } spu_in_t;

    // both operator results, aligned on the same cycle
    typedef struct packed {
        spu_result_t  mul;      // shifted and truncated product
        spu_result_t  sum;      // sum modulo 2^16
    } spu_out_t;

endpackage

`default_nettype wire

// ==== spu_stim.txt ====
# one line per clock, driven after a rising edge, outputs checked before the next
# cke clear valid data0 data1 exp_mul exp_sum   (all hex, exp is m_out at that cycle)
# after reset, valid low, outputs at clear value
1 0 0 1111 2222 0000 0000
1 0 0 3333 4444 0000 0000
# back-to-back multiply corners, results three enabled edges later
1 0 1 0000 0000 0000 0000
1 0 1 FFFF FFFF 0000 0000
1 0 1 8000 0002 0000 0000
1 0 1 8000 8000 0000 0000
1 0 1 7FFF 7FFF FE00 FFFE
1 0 1 7FFF 0100 0100 8002
1 0 1 0001 0001 0000 0000
1 0 1 0100 0100 FF00 FFFE
1 0 1 0010 1000 7FFF 80FF
1 0 1 8000 0100 0000 0002
1 0 1 FFFE FFFE 0100 0200
1 0 1 7FFF FFFF 0100 1010
1 0 1 FEFF 0100 8000 8100
1 0 1 FFFF 0001 FC00 FFFC
# valid low, outputs hold the last result
1 0 0 AAAA 5555 FE80 7FFE
1 0 0 5555 AAAA FEFF FFFF
1 0 0 0000 0000 00FF 0000
1 0 0 0000 0000 00FF 0000
# clear together with valid, clear wins
1 1 1 1234 5678 00FF 0000
1 0 1 1234 5678 00FF 0000
1 0 0 0000 0000 00FF 0000
# clear alone
1 1 0 0000 0000 0000 0000
1 0 0 0000 0000 2600 68AC
1 0 0 0000 0000 2600 68AC
1 0 0 0000 0000 0000 0000
# stalls of one to four cycles, inputs ignored while cke is low
1 0 1 00FF 00FF 0000 0000
0 0 1 DEAD BEEF 0000 0000
1 0 1 0400 0003 0000 0000
0 0 1 DEAD BEEF 0000 0000
0 0 1 DEAD BEEF 0000 0000
1 0 1 0200 0300 0000 0000
1 0 1 0080 0080 00FE 01FE
0 0 0 FFFF FFFF 000C 0403
0 1 1 FFFF FFFF 000C 0403
0 0 0 FFFF FFFF 000C 0403
0 0 1 FFFF FFFF 000C 0403
1 0 1 4000 0004 000C 0403
0 0 1 1111 1111 0600 0500
1 0 0 0000 0000 0600 0500
0 0 0 0000 0000 0040 0100
0 0 0 0000 0000 0040 0100
0 0 0 0000 0000 0040 0100
# drain the pipeline
1 0 0 0000 0000 0040 0100
1 0 0 0000 0000 0100 4004
1 0 0 0000 0000 0100 4004
1 0 0 0000 0000 0100 4004

// ==== tb_spu_core.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "spu_cfg.svh"

module tb_spu_core;

    import spu_pkg::*;

    localparam int    CLK_PERIOD   = 100;               // ns
    localparam int    RESET_CYCLES = 16;
    localparam int    SLACK_CYCLES = 20;                // watchdog margin
    localparam string STIM_FILE    = "spu_stim.txt";

    logic     clk;
    logic     reset;
    logic     cke;
    spu_in_t  s_in;
    spu_out_t m_out;

    // stimulus table, one entry per data line of the file
    logic     stim_cke [$];
    spu_in_t  stim_in  [$];
    spu_out_t stim_exp [$];
    int       stim_src [$];     // line number in the file

    int       cur_line;         // file line under check
    bit       stim_loaded;

    spu_core u_dut (
        .clk   (clk),
        .reset (reset),
        .cke   (cke),
        .s_in  (s_in),
        .m_out (m_out)
    );

    // ------------------------------------------------------------
    // clock
    // ------------------------------------------------------------
    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // ------------------------------------------------------------
    // failure reporting and compare tasks
    // ------------------------------------------------------------
    task automatic stop_with_failure(input string why);
        $display("%s", why);
        $display("=== FAIL ===");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_mul(input spu_result_t got, input spu_result_t exp);
        if (got !== exp) begin
            stop_with_failure($sformatf("FAILED m_out.mul: got 0x%h, expected 0x%h (line %0d)",
                                        got, exp, cur_line));
        end
    endtask

    task automatic check_sum(input spu_result_t got, input spu_result_t exp);
        if (got !== exp) begin
            stop_with_failure($sformatf("FAILED m_out.sum: got 0x%h, expected 0x%h (line %0d)",
                                        got, exp, cur_line));
        end
    endtask

    // ------------------------------------------------------------
    // stimulus file
    // ------------------------------------------------------------
    task automatic load_stim();
        int       fd;
        int       line_no;
        int       n;
        string    line;
        int       f_cke;
        int       f_clear;
        int       f_valid;
        int       f_d0;
        int       f_d1;
        int       f_mul;
        int       f_sum;
        spu_in_t  in_word;
        spu_out_t exp_word;
        fd = $fopen(STIM_FILE, "r");
        if (fd == 0) begin
            stop_with_failure({"cannot open the stimulus file ", STIM_FILE});
        end
        line_no = 0;
        while ($fgets(line, fd) != 0) begin
            line_no++;
            if (line.len() == 0 || line[0] == "#" || line[0] == "\n" || line[0] == "\r") begin
                continue;                               // comment or blank
            end
            n = $sscanf(line, "%h %h %h %h %h %h %h",
                        f_cke, f_clear, f_valid, f_d0, f_d1, f_mul, f_sum);
            if (n != 7) begin
                stop_with_failure($sformatf("stimulus line %0d does not hold seven fields",
                                            line_no));
            end
            if (f_cke > 1 || f_clear > 1 || f_valid > 1) begin
                stop_with_failure($sformatf("stimulus line %0d has a flag other than 0 or 1",
                                            line_no));
            end
            if (f_d0 >= (1 << `SPU_DATA_BITS) || f_d1 >= (1 << `SPU_DATA_BITS) ||
                f_mul >= (1 << `SPU_RESULT_BITS) || f_sum >= (1 << `SPU_RESULT_BITS)) begin
                stop_with_failure($sformatf("stimulus line %0d has a value that is too wide",
                                            line_no));
            end
            in_word.data0 = spu_operand_t'(f_d0);
            in_word.data1 = spu_operand_t'(f_d1);
            in_word.clear = f_clear[0];
            in_word.valid = f_valid[0];
            exp_word.mul  = spu_result_t'(f_mul);
            exp_word.sum  = spu_result_t'(f_sum);
            stim_cke.push_back(f_cke[0]);
            stim_in.push_back(in_word);
            stim_exp.push_back(exp_word);
            stim_src.push_back(line_no);
        end
        $fclose(fd);
        if (stim_in.size() == 0) begin
            stop_with_failure("the stimulus file holds no data lines");
        end
    endtask

    task automatic drive_line(input int idx);
        cke  = stim_cke[idx];
        s_in = stim_in[idx];
    endtask

    task automatic check_line(input int idx);
        spu_out_t exp_word;
        exp_word = stim_exp[idx];
        cur_line = stim_src[idx];
        check_mul(m_out.mul, exp_word.mul);
        check_sum(m_out.sum, exp_word.sum);
    endtask

    // ------------------------------------------------------------
    // main sequence
    // ------------------------------------------------------------
    initial begin
        cke         = 1'b0;
        s_in        = '0;
        reset       = 1'b1;
        cur_line    = 0;
        stim_loaded = 1'b0;
        load_stim();
        stim_loaded = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        reset = 1'b0;                                   // first line goes out with it
        for (int i = 0; i < stim_in.size(); i++) begin
            drive_line(i);
            #(CLK_PERIOD - 3);                          // just before the next edge
            check_line(i);
            @(posedge clk);
            #1;
        end
        $display("=== PASS ===");
        $finish;
    end

    // run length follows the number of stimulus lines
    initial begin
        wait (stim_loaded);
        #((stim_in.size() + RESET_CYCLES + SLACK_CYCLES) * CLK_PERIOD);
        stop_with_failure("timeout: the stimulus sequence did not finish in time");
    end

endmodule

`default_nettype wire
